// File: board_pkg.sv
// Shared power state encoding and LFSR constants for the board support RTL and its testbench.
package board_pkg;

    // Power controller states.
    typedef enum logic [1:0] {
        PWR_RESET = 2'd0,
        PWR_RUN   = 2'd1,
        PWR_SHDN  = 2'd2
    } power_state_e;

    // Galois feedback mask for x^128 + x^126 + x^101 + x^99 + 1.
    // Right-shifting form, so tap n sits at bit n-1.
    localparam logic [127:0] lfsr_taps = {
        32'hA000_0014,
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000
    };

    // Load value at reset, any nonzero pattern works.
    localparam logic [127:0] lfsr_seed = {
        32'h9E37_79B9,
        32'h7F4A_7C15,
        32'hF39C_C060,
        32'h5CED_C835
    };

endpackage

// File: power_if.sv
// Power control signals shared between the power controller and the board I/O block.
interface power_if;

    // Debounced center button press, one cycle.
    logic btn_reset;

    // Core reset level.
    logic core_rst;

    // Core clock enable.
    logic core_run;

    // Core is parked in shutdown.
    logic in_shdn;

    // Controller side.
    modport ctrl (
        input  btn_reset,
        output core_rst,
        output core_run,
        output in_shdn
    );

    // Board I/O side, shows the power state on the LEDs.
    modport io (
        output btn_reset,
        input  core_rst,
        input  in_shdn
    );

endinterface

// File: power_ctrl.sv
// Power sequencing FSM that turns core and button requests into core reset and clock enable.
module power_ctrl #(
    parameter logic [7:0] reset_hold = 8'd16
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    pmu_shdn,
    input  logic    pmu_rst,
    power_if.ctrl   pwr
);
    import board_pkg::*;

    power_state_e state;
    power_state_e state_next;
    logic [7:0]   hold_cnt;
    logic         rst_req;

    // Reset requests win over shutdown.
    assign rst_req = pmu_rst || pwr.btn_reset;

    always_comb begin
        state_next = state;
        if (rst_req) begin
            state_next = PWR_RESET;
        end else begin
            case (state)
                PWR_RESET: begin
                    if (hold_cnt == reset_hold - 8'd1) begin
                        state_next = PWR_RUN;
                    end
                end
                PWR_RUN: begin
                    if (pmu_shdn) begin
                        state_next = PWR_SHDN;
                    end
                end
                PWR_SHDN: begin
                    // Only a reset gets the core out of here.
                    state_next = PWR_SHDN;
                end
                default: begin
                    state_next = PWR_RESET;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= PWR_RESET;
            hold_cnt     <= 8'd0;
            pwr.core_rst <= 1'b1;
            pwr.core_run <= 1'b0;
            pwr.in_shdn  <= 1'b0;
        end else begin
            state <= state_next;
            // Hold count restarts on every fresh entry into reset.
            if (rst_req || state != PWR_RESET) begin
                hold_cnt <= 8'd0;
            end else begin
                hold_cnt <= hold_cnt + 8'd1;
            end
            // Outputs follow the next state so they change with it.
            pwr.core_rst <= (state_next == PWR_RESET);
            pwr.core_run <= (state_next == PWR_RUN);
            pwr.in_shdn  <= (state_next == PWR_SHDN);
        end
    end

    // Core never runs while held in reset.
    assert property (@(posedge clk) disable iff (!rst_n)
        !(pwr.core_run && pwr.core_rst));

    // Outside reset the core is either running or shut down.
    assert property (@(posedge clk) disable iff (!rst_n)
        pwr.in_shdn == (!pwr.core_run && !pwr.core_rst));

endmodule

// File: board_io.sv
// Board pad logic with UART pad registers, button synchronizers and debouncers, and status LEDs.
module board_io #(
    parameter logic [15:0] debounce_cycles = 16'd50000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        core_txd,
    output logic        pmod_txd,
    input  logic        pmod_rxd,
    output logic        rxd,
    input  logic        btn_c,
    input  logic        btn_u,
    input  logic        btn_d,
    input  logic        btn_l,
    input  logic        btn_r,
    output logic [7:0]  led,
    power_if.io         pwr
);

    // Button index: 0 center, 1 up, 2 down, 3 left, 4 right.
    localparam int n_btn = 5;

    logic              rx_meta;
    logic [n_btn-1:0]  btn_raw;
    logic [n_btn-1:0]  btn_meta;
    logic [n_btn-1:0]  btn_sync;
    logic [n_btn-1:0]  btn_deb;
    logic [15:0]       deb_cnt [n_btn];
    logic              btn_c_prev;

    assign btn_raw = {btn_r, btn_l, btn_d, btn_u, btn_c};

    // UART pads, idle high.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pmod_txd <= 1'b1;
            rx_meta  <= 1'b1;
            rxd      <= 1'b1;
        end else begin
            pmod_txd <= core_txd;
            rx_meta  <= pmod_rxd;
            rxd      <= rx_meta;
        end
    end

    // Two-flop synchronizers, then one debounce counter per button.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_deb  <= '0;
            for (int i = 0; i < n_btn; i++) begin
                deb_cnt[i] <= 16'd0;
            end
        end else begin
            btn_meta <= btn_raw;
            btn_sync <= btn_meta;
            for (int i = 0; i < n_btn; i++) begin
                if (btn_sync[i] == btn_deb[i]) begin
                    // Any bounce back restarts the wait.
                    deb_cnt[i] <= 16'd0;
                end else if (deb_cnt[i] == debounce_cycles - 16'd1) begin
                    btn_deb[i] <= btn_sync[i];
                    deb_cnt[i] <= 16'd0;
                end else begin
                    deb_cnt[i] <= deb_cnt[i] + 16'd1;
                end
            end
        end
    end

    // Rising edge of the debounced center button.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btn_c_prev <= 1'b0;
        end else begin
            btn_c_prev <= btn_deb[0];
        end
    end

    assign pwr.btn_reset = btn_deb[0] && !btn_c_prev;

    // Status LEDs.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led <= 8'h00;
        end else begin
            led[0]   <= !pmod_txd;
            led[1]   <= !rxd;
            led[2]   <= pwr.core_rst;
            led[3]   <= pwr.in_shdn;
            led[7:4] <= {btn_deb[1], btn_deb[2], btn_deb[3], btn_deb[4]};
        end
    end

    // One press gives one reset request.
    assert property (@(posedge clk) disable iff (!rst_n)
        pwr.btn_reset |=> !pwr.btn_reset);

endmodule

// File: rtc_divider.sv
// Real time clock divider that emits a one-cycle tick at rtc_hz while the core runs.
module rtc_divider #(
    parameter logic [31:0] clk_hz = 32'd100_000_000,
    parameter logic [31:0] rtc_hz = 32'd1_000_000
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    core_run,
    input  logic    core_rst,
    output logic    rtc_tick
);

    localparam logic [31:0] ratio = clk_hz / rtc_hz;

    // Counts from 1 to ratio and sits at 0 only after a core reset.
    logic [31:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n || core_rst) begin
            cnt <= 32'd0;
        end else if (core_run) begin
            if (cnt == ratio) begin
                cnt <= 32'd1;
            end else begin
                cnt <= cnt + 32'd1;
            end
        end
    end

    // Paused counter never ticks.
    assign rtc_tick = core_run && (cnt == ratio);

    // Tick stays quiet during shutdown and reset.
    assert property (@(posedge clk) disable iff (!rst_n)
        rtc_tick |-> (core_run && !core_rst));

endmodule

// File: lfsr_entropy.sv
// Free running 128-bit Galois LFSR used as the board's source of random words.
module lfsr_entropy (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] random
);
    import board_pkg::*;

    logic [127:0] state;
    logic [127:0] feedback;

    // Shifted-out bit folds back through the tap mask.
    assign feedback = state[0] ? lfsr_taps : 128'd0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= lfsr_seed;
        end else begin
            state <= {1'b0, state[127:1]} ^ feedback;
        end
    end

    assign random = state[31:0];

    // All-zero state would lock up the generator.
    assert property (@(posedge clk) disable iff (!rst_n)
        state != 128'd0);

endmodule

// File: board_top.sv
// Board support top level that wires power control, pad I/O, RTC tick and randomness blocks.
module board_top #(
    parameter logic [31:0] clk_hz          = 32'd100_000_000,
    parameter logic [31:0] rtc_hz          = 32'd1_000_000,
    parameter logic [15:0] debounce_cycles = 16'd50000,
    parameter logic [7:0]  reset_hold      = 8'd16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pmu_shdn,
    input  logic        pmu_rst,
    input  logic        core_txd,
    input  logic        pmod_rxd,
    input  logic        btn_c,
    input  logic        btn_u,
    input  logic        btn_d,
    input  logic        btn_l,
    input  logic        btn_r,
    output logic        pmod_txd,
    output logic        rxd,
    output logic        core_rst,
    output logic        core_run,
    output logic        rtc_tick,
    output logic [31:0] random,
    output logic [7:0]  led
);

    power_if pwr_bus ();

    power_ctrl #(
        .reset_hold (reset_hold)
    ) u_power_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .pmu_shdn (pmu_shdn),
        .pmu_rst  (pmu_rst),
        .pwr      (pwr_bus.ctrl)
    );

    board_io #(
        .debounce_cycles (debounce_cycles)
    ) u_board_io (
        .clk      (clk),
        .rst_n    (rst_n),
        .core_txd (core_txd),
        .pmod_txd (pmod_txd),
        .pmod_rxd (pmod_rxd),
        .rxd      (rxd),
        .btn_c    (btn_c),
        .btn_u    (btn_u),
        .btn_d    (btn_d),
        .btn_l    (btn_l),
        .btn_r    (btn_r),
        .led      (led),
        .pwr      (pwr_bus.io)
    );

    rtc_divider #(
        .clk_hz (clk_hz),
        .rtc_hz (rtc_hz)
    ) u_rtc_divider (
        .clk      (clk),
        .rst_n    (rst_n),
        .core_run (pwr_bus.core_run),
        .core_rst (pwr_bus.core_rst),
        .rtc_tick (rtc_tick)
    );

    lfsr_entropy u_lfsr_entropy (
        .clk    (clk),
        .rst_n  (rst_n),
        .random (random)
    );

    // Core side of the power controls.
    assign core_rst = pwr_bus.core_rst;
    assign core_run = pwr_bus.core_run;

endmodule

// File: tb_board_top.sv
// Self-checking testbench for board_top that runs a table of power, button and UART steps.
module tb_board_top;
    import board_pkg::*;

    localparam int clk_period      = 40;
    localparam int drive_delay     = 2;
    localparam int sample_delay    = 1;
    localparam int reset_cycles    = 4;
    localparam int clk_hz          = 1000;
    localparam int rtc_hz          = 100;
    localparam int debounce_cycles = 8;
    localparam int reset_hold      = 4;
    localparam int ratio           = clk_hz / rtc_hz;
    localparam int max_rows        = 32;

    // One test step: inputs, length in cycles, expected results at its end.
    typedef struct packed {
        logic         shdn;
        logic         prst;
        logic         btn;
        logic [3:0]   udlr;
        logic         txd;
        logic         rxd;
        logic         glitch;
        logic [7:0]   cycles;
        power_state_e state;
        logic         led3;
        logic [3:0]   led_btn;
        logic [7:0]   resets;
    } step_t;

    logic        clk;
    logic        rst_n;
    logic        pmu_shdn;
    logic        pmu_rst;
    logic        core_txd;
    logic        pmod_rxd;
    logic        btn_c;
    logic        btn_u;
    logic        btn_d;
    logic        btn_l;
    logic        btn_r;
    logic        pmod_txd;
    logic        rxd;
    logic        core_rst;
    logic        core_run;
    logic        rtc_tick;
    logic [31:0] random;
    logic [7:0]  led;

    step_t       rows [0:max_rows-1];
    int          n_rows = 0;
    int          error_count = 0;
    int          reset_count = 0;
    int          tick_count = 0;
    int          limit_cycles = 0;
    integer      seed;

    board_top #(
        .clk_hz          (clk_hz),
        .rtc_hz          (rtc_hz),
        .debounce_cycles (debounce_cycles),
        .reset_hold      (reset_hold)
    ) DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .pmu_shdn (pmu_shdn),
        .pmu_rst  (pmu_rst),
        .core_txd (core_txd),
        .pmod_rxd (pmod_rxd),
        .btn_c    (btn_c),
        .btn_u    (btn_u),
        .btn_d    (btn_d),
        .btn_l    (btn_l),
        .btn_r    (btn_r),
        .pmod_txd (pmod_txd),
        .rxd      (rxd),
        .core_rst (core_rst),
        .core_run (core_run),
        .rtc_tick (rtc_tick),
        .random   (random),
        .led      (led)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %0t: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Galois step with the shifted-out bit folded back through the taps.
    function automatic logic [127:0] lfsr_step(input logic [127:0] s);
        lfsr_step = (s >> 1) ^ (s[0] ? lfsr_taps : 128'd0);
    endfunction

    task automatic add_row(input logic shdn, input logic prst, input logic btn,
                           input logic [3:0] udlr, input logic txd, input logic rxd_in,
                           input logic glitch, input int cycles, input power_state_e st,
                           input logic led3, input logic [3:0] led_btn, input int resets);
        step_t s;
        s.shdn    = shdn;
        s.prst    = prst;
        s.btn     = btn;
        s.udlr    = udlr;
        s.txd     = txd;
        s.rxd     = rxd_in;
        s.glitch  = glitch;
        s.cycles  = cycles[7:0];
        s.state   = st;
        s.led3    = led3;
        s.led_btn = led_btn;
        s.resets  = resets[7:0];
        rows[n_rows] = s;
        n_rows++;
    endtask

    task automatic build_table();
        // Power-up hold and a run long enough for a tick.
        add_row(0, 0, 0, 4'b0000, 1, 1, 0, reset_hold - 1, PWR_RESET, 0, 4'b0000, 0);
        add_row(0, 0, 0, 4'b0000, 0, 1, 0, 1, PWR_RUN, 0, 4'b0000, 0);
        add_row(0, 0, 0, 4'b0000, 1, 0, 0, 12, PWR_RUN, 0, 4'b0000, 0);
        // Shutdown with the LED one cycle behind.
        add_row(1, 0, 0, 4'b0000, 0, 0, 0, 1, PWR_SHDN, 0, 4'b0000, 0);
        add_row(0, 0, 0, 4'b0000, 1, 1, 0, 15, PWR_SHDN, 1, 4'b0000, 0);
        // Core reset request brings it back.
        add_row(0, 1, 0, 4'b0000, 0, 1, 0, 1, PWR_RESET, 1, 4'b0000, 1);
        add_row(0, 0, 0, 4'b0000, 1, 0, 0, reset_hold - 1, PWR_RESET, 0, 4'b0000, 1);
        add_row(0, 0, 0, 4'b0000, 0, 0, 0, 1, PWR_RUN, 0, 4'b0000, 1);
        add_row(0, 0, 0, 4'b0000, 0, 1, 0, 24, PWR_RUN, 0, 4'b0000, 1);
        // Short center glitches must not reset.
        add_row(0, 0, 1, 4'b0000, 1, 1, 1, 14, PWR_RUN, 0, 4'b0000, 1);
        add_row(0, 0, 1, 4'b0000, 0, 1, 1, 14, PWR_RUN, 0, 4'b0000, 1);
        add_row(0, 0, 1, 4'b0000, 1, 0, 1, 14, PWR_RUN, 0, 4'b0000, 1);
        // Held press needs two sync cycles plus the edge into the controller.
        add_row(0, 0, 1, 4'b0000, 0, 0, 0, debounce_cycles + 3, PWR_RESET, 0, 4'b0000, 2);
        add_row(0, 0, 1, 4'b0000, 1, 1, 0, reset_hold, PWR_RUN, 0, 4'b0000, 2);
        add_row(0, 0, 0, 4'b0000, 0, 1, 0, 14, PWR_RUN, 0, 4'b0000, 2);
        // Direction buttons on the upper LEDs.
        add_row(0, 0, 0, 4'b1010, 1, 0, 0, 14, PWR_RUN, 0, 4'b1010, 2);
        add_row(0, 0, 0, 4'b0101, 0, 0, 0, 14, PWR_RUN, 0, 4'b0101, 2);
        add_row(0, 0, 0, 4'b0000, 1, 1, 0, 14, PWR_RUN, 0, 4'b0000, 2);
        // Reset wins over a shutdown in the same cycle.
        add_row(1, 1, 0, 4'b0000, 0, 1, 0, 1, PWR_RESET, 0, 4'b0000, 3);
        add_row(0, 0, 0, 4'b0000, 1, 0, 0, reset_hold, PWR_RUN, 0, 4'b0000, 3);
        add_row(0, 0, 0, 4'b0000, 0, 1, 0, 12, PWR_RUN, 0, 4'b0000, 3);
    endtask

    // Per-cycle checks of the LFSR, UART pads, LEDs, tick spacing and reset entries.
    initial begin
        logic [127:0] model;
        logic         prev_rst;
        logic         prev_core_txd;
        logic         prev_pmod_rxd;
        logic         prev2_pmod_rxd;
        logic         prev_core_rst;
        logic         prev_core_run;
        logic         exp_tick;
        int           run_cnt;
        model    = lfsr_seed;
        prev_rst = 1'b0;
        run_cnt  = 0;
        forever begin
            @(posedge clk);
            #sample_delay;
            if (rst_n) begin
                model = lfsr_step(model);
            end else begin
                model = lfsr_seed;
            end
            check_value(random, model[31:0], "random word");
            if (rst_n) begin
                check_value(pmod_txd, core_txd, "pmod_txd");
                check_value(led[0], !prev_core_txd, "led[0]");
                check_value(led[1], !prev2_pmod_rxd, "led[1]");
                check_value(led[2], prev_core_rst, "led[2]");
                if (prev_rst) begin
                    check_value(rxd, prev_pmod_rxd, "rxd");
                end
                if (core_rst && !prev_core_rst) begin
                    reset_count++;
                end
                if (core_rst) begin
                    run_cnt = 0;
                end else if (prev_core_run) begin
                    run_cnt++;
                end
                exp_tick = core_run && (run_cnt != 0) && (run_cnt % ratio == 0);
                check_value(rtc_tick, exp_tick, "rtc_tick");
                if (rtc_tick) begin
                    tick_count++;
                end
            end
            prev_rst       = rst_n;
            prev_core_txd  = core_txd;
            prev2_pmod_rxd = prev_pmod_rxd;
            prev_pmod_rxd  = pmod_rxd;
            prev_core_rst  = core_rst;
            prev_core_run  = core_run;
        end
    end

    // Watchdog.
    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: the test did not finish within %0d clock cycles.", limit_cycles);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        step_t row;
        int    total;
        int    glitch_len;
        seed     = 32'hf033;
        rst_n    = 1'b0;
        pmu_shdn = 1'b0;
        pmu_rst  = 1'b0;
        core_txd = 1'b1;
        pmod_rxd = 1'b1;
        btn_c    = 1'b0;
        btn_u    = 1'b0;
        btn_d    = 1'b0;
        btn_l    = 1'b0;
        btn_r    = 1'b0;
        build_table();
        total = 0;
        for (int r = 0; r < n_rows; r++) begin
            total += rows[r].cycles;
        end
        limit_cycles = reset_cycles + total + 50;

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;

        for (int r = 0; r < n_rows; r++) begin
            row = rows[r];
            glitch_len = 1 + ({$random(seed)} % (debounce_cycles - 1));
            for (int c = 0; c < row.cycles; c++) begin
                pmu_shdn = row.shdn;
                pmu_rst  = row.prst;
                core_txd = row.txd;
                pmod_rxd = row.rxd;
                btn_c    = row.glitch ? (c < glitch_len) : row.btn;
                {btn_u, btn_d, btn_l, btn_r} = row.udlr;
                @(posedge clk);
                #drive_delay;
            end
            check_value(core_rst, row.state == PWR_RESET, $sformatf("step %0d core_rst", r));
            check_value(core_run, row.state == PWR_RUN, $sformatf("step %0d core_run", r));
            check_value(led[3], row.led3, $sformatf("step %0d led[3]", r));
            check_value(led[7:4], row.led_btn, $sformatf("step %0d led[7:4]", r));
            check_value(reset_count, row.resets, $sformatf("step %0d reset entries", r));
        end
        check_value(tick_count != 0, 1, "rtc ticks seen");

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
board_pkg.sv
power_if.sv
power_ctrl.sv
board_io.sv
rtc_divider.sv
lfsr_entropy.sv
board_top.sv
tb_board_top.sv

// File: Bender.yml
package:
  name: board_support

sources:
  - board_pkg.sv
  - power_if.sv
  - power_ctrl.sv
  - board_io.sv
  - rtc_divider.sv
  - lfsr_entropy.sv
  - board_top.sv
  - target: test
    files:
      - tb_board_top.sv
